// ==== verilog/cache_settings.svh ====
// ----------------------------------------
// Size macros for the direct-mapped cache
// lookup path
// ----------------------------------------

`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Number of lines in the cache, one word per line
`define CACHE_DEPTH 64

// Line index width, log2 of the depth
`define INDEX_BITS 6

// Stored tag width and cached word width
`define TAG_BITS 8
`define DATA_BITS 32

// A request address is the tag on top of the index
`define ADDR_BITS (`TAG_BITS + `INDEX_BITS)

`endif

// ==== verilog/cache_pkg.sv ====
// ----------------------------------------
// Vector types shared by the cache lookup
// path and its testbench
// ----------------------------------------

`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

    // Selects one line of every stage-one memory
    typedef logic [`INDEX_BITS-1:0] index_t;

    // Upper address bits kept beside each line
    typedef logic [`TAG_BITS-1:0] tag_t;

    // Full request address, tag above index
    typedef logic [`ADDR_BITS-1:0] line_addr_t;

    // One cached word
    typedef logic [`DATA_BITS-1:0] data_t;

endpackage : cache_pkg

`default_nettype wire

// ==== verilog/tag_memory_fpga.sv ====
// ----------------------------------------
// Tag storage with a read/write port and
// a read-only port, registered outputs
// ----------------------------------------

`default_nettype none

`include "cache_settings.svh"

module tag_memory_fpga import cache_pkg::*; (
    input  logic clk_i,

    // Port 0 is shared by refill writes and probe reads
    input  index_t port0_address_i,
    input  tag_t   port0_tag_i,
    input  logic   port0_write_i,
    input  logic   port0_read_i,
    output tag_t   port0_tag_o,

    // Port 1 serves the lookup side
    input  index_t port1_address_i,
    input  logic   port1_read_i,
    output tag_t   port1_tag_o
);

    // Inferred block memory, one tag per line
    tag_t tag_mem [`CACHE_DEPTH];

    // A write wins over a read on port 0, so the read is simply dropped
    // The output register keeps its last value when nothing is read
    always_ff @(posedge clk_i) begin : port0_access
        if (port0_write_i) begin
            tag_mem[port0_address_i] <= port0_tag_i;
        end else if (port0_read_i) begin
            port0_tag_o <= tag_mem[port0_address_i];
        end
    end : port0_access

    // Port 1 reads the contents from before a same-cycle port 0 write
    always_ff @(posedge clk_i) begin : port1_access
        if (port1_read_i) begin
            port1_tag_o <= tag_mem[port1_address_i];
        end
    end : port1_access

endmodule : tag_memory_fpga

`default_nettype wire

// ==== verilog/valid_memory.sv ====
// ----------------------------------------
// Resettable valid-bit array with a probe
// port and a lookup read port
// ----------------------------------------

`default_nettype none

`include "cache_settings.svh"

module valid_memory import cache_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_i,

    // Port 0 sets, clears or probes one line
    input  index_t port0_address_i,
    input  logic   port0_set_i,
    input  logic   port0_clear_i,
    input  logic   port0_read_i,
    output logic   port0_valid_o,
    output logic   port0_ack_o,

    // Port 1 serves the lookup side
    input  index_t port1_address_i,
    input  logic   port1_read_i,
    output logic   port1_valid_o
);

    // One flip-flop per line
    logic [`CACHE_DEPTH-1:0] valid_bits;

    // A port 0 read only goes through when no set or clear is present
    logic port0_read_ok;

    assign port0_read_ok = port0_read_i & ~port0_set_i & ~port0_clear_i;

    // ----------------------------------------
    // Port 0
    // ----------------------------------------

    // Reset empties the whole cache; set takes precedence over clear
    always_ff @(posedge clk_i) begin : port0_access
        if (reset_i) begin
            valid_bits    <= '0;
            port0_valid_o <= 1'b0;
            port0_ack_o   <= 1'b0;
        end else begin
            if (port0_set_i) begin
                valid_bits[port0_address_i] <= 1'b1;
            end else if (port0_clear_i) begin
                valid_bits[port0_address_i] <= 1'b0;
            end
            // The acknowledge pulses for one cycle after an accepted probe
            port0_ack_o <= port0_read_ok;
            if (port0_read_ok) begin
                port0_valid_o <= valid_bits[port0_address_i];
            end
        end
    end : port0_access

    // ----------------------------------------
    // Port 1
    // ----------------------------------------

    // Sees the bit as it was before a same-cycle set or clear
    always_ff @(posedge clk_i) begin : port1_access
        if (reset_i) begin
            port1_valid_o <= 1'b0;
        end else if (port1_read_i) begin
            port1_valid_o <= valid_bits[port1_address_i];
        end
    end : port1_access

endmodule : valid_memory

`default_nettype wire

// ==== verilog/data_memory.sv ====
// ----------------------------------------
// Simple dual-port word storage, written
// on refill and read by lookups
// ----------------------------------------

`default_nettype none

`include "cache_settings.svh"

module data_memory import cache_pkg::*; (
    input  logic   clk_i,

    // Write port, driven by the refill controller
    input  logic   write_i,
    input  index_t write_address_i,
    input  data_t  write_data_i,

    // Read port, driven by the lookup request
    input  logic   read_i,
    input  index_t read_address_i,
    output data_t  read_data_o
);

    // Inferred block memory, one word per line
    data_t data_mem [`CACHE_DEPTH];

    // Write side
    always_ff @(posedge clk_i) begin : write_port
        if (write_i) begin
            data_mem[write_address_i] <= write_data_i;
        end
    end : write_port

    // Read side with an output register
    // On an address collision the old word comes out, which matches
    // the read-first behavior of the tag and valid memories
    always_ff @(posedge clk_i) begin : read_port
        if (read_i) begin
            read_data_o <= data_mem[read_address_i];
        end
    end : read_port

endmodule : data_memory

`default_nettype wire

// ==== verilog/hit_compare_stage.sv ====
// ----------------------------------------
// Second lookup stage with the tag compare,
// hit or miss decision and result register
// ----------------------------------------

`default_nettype none

`include "cache_settings.svh"

module hit_compare_stage import cache_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,

    // Registered request from stage one
    input  logic  lookup_q_i,
    input  tag_t  lookup_tag_i,

    // Memory outputs for the requested line
    input  tag_t  stored_tag_i,
    input  logic  stored_valid_i,
    input  data_t stored_data_i,

    // Lookup result, valid for one cycle
    output logic  result_valid_o,
    output logic  hit_o,
    output logic  miss_o,
    output data_t lookup_data_o
);

    // ----------------------------------------
    // Hit detection
    // ----------------------------------------

    logic tag_match;
    logic hit_now;
    logic miss_now;

    assign tag_match = (stored_tag_i == lookup_tag_i);

    // A hit needs a live request, a valid line and equal tags
    assign hit_now  = lookup_q_i & stored_valid_i & tag_match;
    // Every other request is a miss
    assign miss_now = lookup_q_i & ~hit_now;

    // ----------------------------------------
    // Result register
    // ----------------------------------------

    always_ff @(posedge clk_i) begin : result_ctrl
        if (reset_i) begin
            result_valid_o <= 1'b0;
            hit_o          <= 1'b0;
            miss_o         <= 1'b0;
        end else begin
            result_valid_o <= lookup_q_i;
            hit_o          <= hit_now;
            miss_o         <= miss_now;
        end
    end : result_ctrl

    // The word is forwarded on a hit; misses and idle cycles give zero
    always_ff @(posedge clk_i) begin : result_data
        lookup_data_o <= hit_now ? stored_data_i : {`DATA_BITS{1'b0}};
    end : result_data

endmodule : hit_compare_stage

`default_nettype wire

// ==== verilog/cache_lookup_top.sv ====
// ----------------------------------------
// Direct-mapped cache lookup path with
// refill, invalidate and probe access
// ----------------------------------------

`default_nettype none

`include "cache_settings.svh"

module cache_lookup_top import cache_pkg::*; (
    input  logic       clk_i,
    input  logic       reset_i,

    // Lookup request
    input  logic       lookup_i,
    input  line_addr_t lookup_addr_i,

    // Refill and invalidate from the refill controller
    input  logic       refill_i,
    input  logic       invalidate_i,
    input  line_addr_t refill_addr_i,
    input  data_t      refill_data_i,

    // Probe request
    input  logic       probe_i,
    input  index_t     probe_index_i,

    // Lookup result, two cycles after the request
    output logic       result_valid_o,
    output logic       hit_o,
    output logic       miss_o,
    output data_t      lookup_data_o,

    // Probe result, one cycle after the request
    output logic       probe_ack_o,
    output logic       probe_valid_o,
    output tag_t       probe_tag_o
);

    // ----------------------------------------
    // Address split and port 0 selection
    // ----------------------------------------

    index_t lookup_index;
    tag_t   lookup_tag;
    index_t refill_index;
    tag_t   refill_tag;
    index_t port0_index;

    assign lookup_index = lookup_addr_i[`INDEX_BITS-1:0];
    assign lookup_tag   = lookup_addr_i[`ADDR_BITS-1:`INDEX_BITS];
    assign refill_index = refill_addr_i[`INDEX_BITS-1:0];
    assign refill_tag   = refill_addr_i[`ADDR_BITS-1:`INDEX_BITS];

    // Writes own port 0; the probe index only gets through on idle cycles
    assign port0_index = (refill_i | invalidate_i) ? refill_index : probe_index_i;

    // ----------------------------------------
    // Stage one request registers
    // ----------------------------------------

    logic lookup_q;
    tag_t lookup_tag_q;

    always_ff @(posedge clk_i) begin : stage1_ctrl
        if (reset_i) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_i;
        end
    end : stage1_ctrl

    // The request tag travels beside the memory read data
    always_ff @(posedge clk_i) begin : stage1_tag
        if (lookup_i) begin
            lookup_tag_q <= lookup_tag;
        end
    end : stage1_tag

    // ----------------------------------------
    // Stage one memories
    // ----------------------------------------

    tag_t  stored_tag;
    logic  stored_valid;
    data_t stored_data;

    tag_memory_fpga i_tag_memory (
        .clk_i           (clk_i),
        .port0_address_i (port0_index),
        .port0_tag_i     (refill_tag),
        .port0_write_i   (refill_i),
        .port0_read_i    (probe_i),
        .port0_tag_o     (probe_tag_o),
        .port1_address_i (lookup_index),
        .port1_read_i    (lookup_i),
        .port1_tag_o     (stored_tag)
    );

    // Its acknowledge doubles as the probe acknowledge
    valid_memory i_valid_memory (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .port0_address_i (port0_index),
        .port0_set_i     (refill_i),
        .port0_clear_i   (invalidate_i),
        .port0_read_i    (probe_i),
        .port0_valid_o   (probe_valid_o),
        .port0_ack_o     (probe_ack_o),
        .port1_address_i (lookup_index),
        .port1_read_i    (lookup_i),
        .port1_valid_o   (stored_valid)
    );

    data_memory i_data_memory (
        .clk_i           (clk_i),
        .write_i         (refill_i),
        .write_address_i (refill_index),
        .write_data_i    (refill_data_i),
        .read_i          (lookup_i),
        .read_address_i  (lookup_index),
        .read_data_o     (stored_data)
    );

    // ----------------------------------------
    // Stage two
    // ----------------------------------------

    hit_compare_stage i_hit_compare (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .lookup_q_i     (lookup_q),
        .lookup_tag_i   (lookup_tag_q),
        .stored_tag_i   (stored_tag),
        .stored_valid_i (stored_valid),
        .stored_data_i  (stored_data),
        .result_valid_o (result_valid_o),
        .hit_o          (hit_o),
        .miss_o         (miss_o),
        .lookup_data_o  (lookup_data_o)
    );

endmodule : cache_lookup_top

`default_nettype wire

// ==== dv/cache_lookup_assert.sv ====
// ----------------------------------------
// Concurrent checks on strobes and result
// timing, bound to the lookup top level
// ----------------------------------------

`default_nettype none

module cache_lookup_assert (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic lookup_i,
    input  wire logic refill_i,
    input  wire logic invalidate_i,
    input  wire logic probe_i,
    input  wire logic result_valid_i,
    input  wire logic hit_i,
    input  wire logic miss_i,
    input  wire logic probe_ack_i
);

    // The refill controller drives one port 0 write at a time
    a_single_write : assert property (@(posedge clk_i) disable iff (reset_i)
        !(refill_i && invalidate_i))
        else $error("refill and invalidate asserted together");

    // Fixed two cycle lookup latency
    a_result_latency : assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_i == $past(lookup_i, 2))
        else $error("result_valid_o does not follow lookup_i by two cycles");

    // Exactly one outcome per result, none on idle cycles
    a_hit_miss_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
        result_valid_i ? $onehot({hit_i, miss_i}) : !(hit_i || miss_i))
        else $error("hit_o and miss_o are not consistent with result_valid_o");

    // A probe that meets a write is dropped
    a_probe_dropped : assert property (@(posedge clk_i) disable iff (reset_i)
        (probe_i && (refill_i || invalidate_i)) |=> !probe_ack_i)
        else $error("probe_ack_o raised for a probe issued with a write");

endmodule : cache_lookup_assert

bind cache_lookup_top cache_lookup_assert i_assert (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lookup_i       (lookup_i),
    .refill_i       (refill_i),
    .invalidate_i   (invalidate_i),
    .probe_i        (probe_i),
    .result_valid_i (result_valid_o),
    .hit_i          (hit_o),
    .miss_i         (miss_o),
    .probe_ack_i    (probe_ack_o)
);

`default_nettype wire

// ==== dv/cache_lookup_tb.sv ====
// ----------------------------------------
// Testbench for the cache lookup path with
// a reference model and result compare
// ----------------------------------------

`default_nettype none

`include "cache_settings.svh"

module cache_lookup_tb import cache_pkg::*; ();

    logic clk_i, reset_i, lookup_i, refill_i, invalidate_i, probe_i;
    line_addr_t lookup_addr_i, refill_addr_i;
    data_t refill_data_i, lookup_data_o;
    index_t probe_index_i;
    logic result_valid_o, hit_o, miss_o, probe_ack_o, probe_valid_o;
    tag_t probe_tag_o;

    cache_lookup_top i_dut (.*);

    // Reference state of the cache, plus a flag for lines that hold a known tag
    logic  model_valid [`CACHE_DEPTH];
    logic  model_written [`CACHE_DEPTH];
    tag_t  model_tag [`CACHE_DEPTH];
    data_t model_data [`CACHE_DEPTH];

    // Pending results, each with the cycle in which it is due
    int lk_due[$];
    logic lk_hit[$];
    data_t lk_data[$];
    int pr_due[$];
    logic pr_valid[$];
    logic pr_known[$];
    tag_t pr_tag[$];
    int cycle_count = 0;

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end : clock_gen

    always @(posedge clk_i) cycle_count <= cycle_count + 1;

    // ----------------------------------------
    // Reference model and compare helpers
    // ----------------------------------------

    function automatic line_addr_t join_addr(input tag_t tag, input index_t index);
        return {tag, index};
    endfunction

    // Hit needs a valid line with an equal tag; a miss returns zero
    function automatic void ref_lookup(input line_addr_t addr, output logic hit,
                                       output data_t data);
        index_t index;
        index = addr[`INDEX_BITS-1:0];
        hit = model_valid[index] && (model_tag[index] == addr[`ADDR_BITS-1:`INDEX_BITS]);
        data = hit ? model_data[index] : '0;
    endfunction

    function automatic void ref_probe(input index_t index, output logic valid,
                                      output tag_t tag, output logic known);
        valid = model_valid[index];
        tag = model_tag[index];
        known = model_written[index];
    endfunction

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_tag(input string name, input tag_t actual, input tag_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    // Drives one cycle, queues what the DUT must answer, then applies the write
    task automatic apply_cycle(input logic do_lookup, input line_addr_t l_addr,
                               input logic do_refill, input logic do_inval,
                               input line_addr_t w_addr, input data_t w_data,
                               input logic do_probe, input index_t p_index);
        logic   exp_hit, exp_valid, exp_known;
        data_t  exp_data;
        tag_t   exp_tag;
        index_t w_index;
        @(posedge clk_i);
        #10;
        lookup_i = do_lookup;
        lookup_addr_i = l_addr;
        refill_i = do_refill;
        invalidate_i = do_inval;
        refill_addr_i = w_addr;
        refill_data_i = w_data;
        probe_i = do_probe;
        probe_index_i = p_index;
        // Expectations use the state from before this cycle's write
        if (do_lookup) begin
            ref_lookup(l_addr, exp_hit, exp_data);
            lk_due.push_back(cycle_count + 2);
            lk_hit.push_back(exp_hit);
            lk_data.push_back(exp_data);
        end
        // A probe that meets a write gets no answer at all
        if (do_probe && !do_refill && !do_inval) begin
            ref_probe(p_index, exp_valid, exp_tag, exp_known);
            pr_due.push_back(cycle_count + 1);
            pr_valid.push_back(exp_valid);
            pr_tag.push_back(exp_tag);
            pr_known.push_back(exp_known);
        end
        w_index = w_addr[`INDEX_BITS-1:0];
        if (do_refill) begin
            model_valid[w_index] = 1'b1;
            model_written[w_index] = 1'b1;
            model_tag[w_index] = w_addr[`ADDR_BITS-1:`INDEX_BITS];
            model_data[w_index] = w_data;
        end else if (do_inval) begin
            model_valid[w_index] = 1'b0;
        end
    endtask

    task automatic idle_cycle();
        apply_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic lookup_once(input line_addr_t addr);
        apply_cycle(1'b1, addr, 1'b0, 1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic refill_line(input line_addr_t addr, input data_t data);
        apply_cycle(1'b0, '0, 1'b1, 1'b0, addr, data, 1'b0, '0);
    endtask

    task automatic invalidate_line(input line_addr_t addr);
        apply_cycle(1'b0, '0, 1'b0, 1'b1, addr, '0, 1'b0, '0);
    endtask

    task automatic probe_line(input index_t index);
        apply_cycle(1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b1, index);
    endtask

    initial begin : run_test
        logic [31:0] rand_word;
        logic [31:0] rand_data;
        int drain_wait;
        void'($urandom(32'hd099b7c7));
        reset_i = 1'b1;
        lookup_i = 1'b0;
        refill_i = 1'b0;
        invalidate_i = 1'b0;
        probe_i = 1'b0;
        lookup_addr_i = '0;
        refill_addr_i = '0;
        refill_data_i = '0;
        probe_index_i = '0;
        for (int i = 0; i < `CACHE_DEPTH; i++) begin
            model_valid[i] = 1'b0;
            model_written[i] = 1'b0;
        end
        repeat (8) @(posedge clk_i);
        #10 reset_i = 1'b0;

        // An empty cache misses everywhere
        for (int i = 0; i < 8; i++) begin
            rand_word = $urandom();
            lookup_once(join_addr(tag_t'(rand_word), index_t'(rand_word >> 8)));
        end
        // Refill, then hit and a same-index miss with another tag
        refill_line(join_addr(8'h5a, 6'd3), 32'hcafe_0003);
        refill_line(join_addr(8'h21, 6'd9), 32'h1234_5609);
        lookup_once(join_addr(8'h5a, 6'd3));
        lookup_once(join_addr(8'h5b, 6'd3));
        lookup_once(join_addr(8'h21, 6'd9));
        // Invalidate one line, the other keeps hitting
        invalidate_line(join_addr(8'h5a, 6'd3));
        lookup_once(join_addr(8'h5a, 6'd3));
        lookup_once(join_addr(8'h21, 6'd9));
        // Probes, including two that collide with a write and are dropped
        probe_line(6'd9);
        probe_line(6'd3);
        apply_cycle(1'b0, '0, 1'b1, 1'b0, join_addr(8'h77, 6'd20), 32'h0bad_f00d, 1'b1, 6'd9);
        apply_cycle(1'b0, '0, 1'b0, 1'b1, join_addr(8'h21, 6'd9), '0, 1'b1, 6'd9);
        probe_line(6'd20);
        probe_line(6'd9);

        // Random traffic on four indexes and two tags so collisions are common
        for (int i = 0; i < 400; i++) begin
            rand_word = $urandom();
            rand_data = $urandom();
            apply_cycle(rand_word[1:0] != 2'b00,
                        join_addr(rand_word[11] ? 8'h10 : 8'h11, index_t'(rand_word[10:9])),
                        rand_word[4:2] < 3'd3, rand_word[4:2] == 3'd3,
                        join_addr(rand_word[14] ? 8'h10 : 8'h11, index_t'(rand_word[13:12])),
                        rand_data, rand_word[16:15] == 2'b00, index_t'(rand_word[18:17]));
        end
        idle_cycle();

        drain_wait = 0;
        while (lk_due.size() != 0 || pr_due.size() != 0) begin
            @(posedge clk_i);
            drain_wait++;
            if (drain_wait > 10) begin
                $display("Timeout while waiting for the outstanding results");
                stop_with_failure();
            end
        end
        @(posedge clk_i);
        $display("*** PASSED ***");
        $finish;
    end : run_test

    // ----------------------------------------
    // Result compare
    // ----------------------------------------

    // Samples on the falling edge, halfway between the DUT register updates
    initial begin : compare_results
        int   reset_wait;
        logic exp_hit, exp_valid, exp_known;
        data_t exp_data;
        tag_t exp_tag;
        reset_wait = 0;
        #1;
        while (reset_i) begin
            @(posedge clk_i);
            reset_wait++;
            if (reset_wait > 20) begin
                $display("Reset was never released");
                stop_with_failure();
            end
        end
        forever begin
            @(negedge clk_i);
            if (lk_due.size() != 0 && lk_due[0] == cycle_count) begin
                lk_due.delete(0);
                exp_hit = lk_hit.pop_front();
                exp_data = lk_data.pop_front();
                check_bit("result_valid_o", result_valid_o, 1'b1);
                check_bit("hit_o", hit_o, exp_hit);
                check_bit("miss_o", miss_o, ~exp_hit);
                check_data("lookup_data_o", lookup_data_o, exp_data);
            end else begin
                check_bit("result_valid_o", result_valid_o, 1'b0);
            end
            if (pr_due.size() != 0 && pr_due[0] == cycle_count) begin
                pr_due.delete(0);
                exp_valid = pr_valid.pop_front();
                exp_tag = pr_tag.pop_front();
                exp_known = pr_known.pop_front();
                check_bit("probe_ack_o", probe_ack_o, 1'b1);
                check_bit("probe_valid_o", probe_valid_o, exp_valid);
                // A line that was never refilled holds no defined tag
                if (exp_known) begin
                    check_tag("probe_tag_o", probe_tag_o, exp_tag);
                end
            end else begin
                check_bit("probe_ack_o", probe_ack_o, 1'b0);
            end
        end
    end : compare_results

endmodule : cache_lookup_tb

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/tag_memory_fpga.sv
verilog/valid_memory.sv
verilog/data_memory.sv
verilog/hit_compare_stage.sv
verilog/cache_lookup_top.sv
dv/cache_lookup_assert.sv
dv/cache_lookup_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache lookup testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f \
    --top-module cache_lookup_tb -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vcache_lookup_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
